// File: logic/axi_lite_target.sv
`include "nic_defines.svh"

module axi_lite_target (
	input  logic                   core_clk,
	input  logic                   core_rst,

	input  logic                   s_awvalid_i,
	output logic                   s_awready_o,
	input  logic [`NIC_ADDR_W-1:0] s_awaddr_i,

	input  logic                   s_wvalid_i,
	output logic                   s_wready_o,
	input  logic [`NIC_DATA_W-1:0] s_wdata_i,
	input  logic [`NIC_STRB_W-1:0] s_wstrb_i,

	output logic                   s_bvalid_o,
	input  logic                   s_bready_i,
	output nic_pkg::resp_e         s_bresp_o,

	input  logic                   s_arvalid_i,
	output logic                   s_arready_o,
	input  logic [`NIC_ADDR_W-1:0] s_araddr_i,

	output logic                   s_rvalid_o,
	input  logic                   s_rready_i,
	output logic [`NIC_DATA_W-1:0] s_rdata_o,
	output nic_pkg::resp_e         s_rresp_o,

	reg_bus_if.initiator           bus_o
);

	// Transaction sequencer states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0]             state_q;
	logic [1:0]             state_n;

	// Channel holding registers
	logic                   aw_held_q;
	logic                   w_held_q;
	logic                   ar_held_q;
	logic [`NIC_ADDR_W-1:0] aw_addr_q;
	logic [`NIC_ADDR_W-1:0] ar_addr_q;
	logic [`NIC_DATA_W-1:0] w_data_q;
	logic [`NIC_STRB_W-1:0] w_strb_q;

	logic                   awready_q;
	logic                   wready_q;
	logic                   arready_q;

	// Request in flight on the register bus
	logic                   req_write_q;
	logic [`NIC_ADDR_W-1:0] req_addr_q;
	logic [`NIC_DATA_W-1:0] req_wdata_q;
	logic [`NIC_STRB_W-1:0] req_strb_q;

	// Response channel registers
	logic                   bvalid_q;
	logic                   rvalid_q;
	nic_pkg::resp_e         bresp_q;
	nic_pkg::resp_e         rresp_q;
	logic [`NIC_DATA_W-1:0] rdata_q;

	logic aw_take;
	logic w_take;
	logic ar_take;
	logic launch_wr;
	logic launch_rd;
	logic aw_held_n;
	logic w_held_n;
	logic ar_held_n;

	always_comb begin
		aw_take = s_awvalid_i && awready_q;
		w_take  = s_wvalid_i && wready_q;
		ar_take = s_arvalid_i && arready_q;

		// A complete write wins over a pending read
		launch_wr = (state_q == ST_IDLE) && aw_held_q && w_held_q;
		launch_rd = (state_q == ST_IDLE) && ar_held_q && !launch_wr;

		aw_held_n = (aw_held_q && !launch_wr) || aw_take;
		w_held_n  = (w_held_q && !launch_wr) || w_take;
		ar_held_n = (ar_held_q && !launch_rd) || ar_take;

		state_n = state_q;
		case (state_q)
			ST_IDLE: begin
				if (launch_wr || launch_rd)
					state_n = ST_REQ;
			end
			ST_REQ: begin
				if (bus_o.req_ready)
					state_n = ST_WAIT;
			end
			ST_WAIT: begin
				if (bus_o.rsp_valid)
					state_n = ST_RESP;
			end
			default: begin
				if ((bvalid_q && s_bready_i) || (rvalid_q && s_rready_i))
					state_n = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			state_q   <= ST_IDLE;
			aw_held_q <= 1'b0;
			w_held_q  <= 1'b0;
			ar_held_q <= 1'b0;
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			arready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
			bresp_q   <= nic_pkg::OKAY;
			rresp_q   <= nic_pkg::OKAY;
		end else begin
			state_q   <= state_n;
			aw_held_q <= aw_held_n;
			w_held_q  <= w_held_n;
			ar_held_q <= ar_held_n;

			// Channels open only while idle with a free slot
			awready_q <= (state_n == ST_IDLE) && !aw_held_n;
			wready_q  <= (state_n == ST_IDLE) && !w_held_n;
			arready_q <= (state_n == ST_IDLE) && !ar_held_n;

			// Steer the response to B or R
			if (state_q == ST_WAIT && bus_o.rsp_valid) begin
				if (req_write_q) begin
					bvalid_q <= 1'b1;
					bresp_q  <= bus_o.rsp_resp;
				end else begin
					rvalid_q <= 1'b1;
					rresp_q  <= bus_o.rsp_resp;
				end
			end
			if (bvalid_q && s_bready_i)
				bvalid_q <= 1'b0;
			if (rvalid_q && s_rready_i)
				rvalid_q <= 1'b0;
		end
	end

	// Payload capture
	always_ff @(posedge core_clk) begin
		if (aw_take)
			aw_addr_q <= s_awaddr_i;
		if (w_take) begin
			w_data_q <= s_wdata_i;
			w_strb_q <= s_wstrb_i;
		end
		if (ar_take)
			ar_addr_q <= s_araddr_i;
		if (launch_wr || launch_rd) begin
			req_write_q <= launch_wr;
			req_addr_q  <= launch_wr ? aw_addr_q : ar_addr_q;
			req_wdata_q <= w_data_q;
			req_strb_q  <= w_strb_q;
		end
		if (state_q == ST_WAIT && bus_o.rsp_valid && !req_write_q)
			rdata_q <= bus_o.rsp_rdata;
	end

	assign bus_o.req_valid = (state_q == ST_REQ);
	assign bus_o.req_write = req_write_q;
	assign bus_o.req_addr  = req_addr_q;
	assign bus_o.req_wdata = req_wdata_q;
	assign bus_o.req_strb  = req_strb_q;

	assign s_awready_o = awready_q;
	assign s_wready_o  = wready_q;
	assign s_arready_o = arready_q;
	assign s_bvalid_o  = bvalid_q;
	assign s_bresp_o   = bresp_q;
	assign s_rvalid_o  = rvalid_q;
	assign s_rdata_o   = rdata_q;
	assign s_rresp_o   = rresp_q;

	// Responses hold steady under back-pressure
	b_hold_a: assert property (@(posedge core_clk) disable iff (core_rst)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

	r_hold_a: assert property (@(posedge core_clk) disable iff (core_rst)
		s_rvalid_o && !s_rready_i |=>
		s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule

// File: logic/config_rom.sv
`include "nic_defines.svh"

module config_rom (
	input  logic                   core_clk,
	input  logic                   rom_ren_i,
	input  logic [`NIC_ROM_AW-1:0] rom_addr_i,
	output logic [15:0]            rom_rdata_o
);

	localparam int IMG_W = 16 * `NIC_ROM_WORDS;

	// Build the word image, last word balances the checksum
	function automatic logic [IMG_W-1:0] build_image();
		logic [IMG_W-1:0] img;
		logic [47:0]      mac;
		logic [15:0]      sum;
		logic [15:0]      word;
		img = '0;
		mac = `NIC_MAC_ADDR;
		sum = '0;
		for (int i = 0; i < `NIC_ROM_WORDS - 1; i++) begin
			// MAC words carry the earlier octet in the low byte
			if (i < 3)
				word = {mac[39-16*i -: 8], mac[47-16*i -: 8]};
			else
				word = {8'h00, ~8'(i)};
			img[16*i +: 16] = word;
			sum = sum + word;
		end
		img[16*(`NIC_ROM_WORDS-1) +: 16] = `NIC_CHECKSUM - sum;
		return img;
	endfunction

	localparam logic [IMG_W-1:0] ROM_IMAGE = build_image();

	logic [15:0] rdata_q;

	// Unpopulated addresses read as erased
	always_ff @(posedge core_clk) begin
		if (rom_ren_i) begin
			if (rom_addr_i < `NIC_ROM_WORDS)
				rdata_q <= ROM_IMAGE[16*rom_addr_i +: 16];
			else
				rdata_q <= 16'hFFFF;
		end
	end

	assign rom_rdata_o = rdata_q;

endmodule

// File: logic/device_top.sv
`include "nic_defines.svh"

module device_top (
	input  logic                   core_clk,
	input  logic                   ext_rst,
	input  logic                   pll_locked_i,
	input  logic                   link_up_i,
	output logic                   intr_o,

	// AXI4-Lite slave from the host side
	input  logic                   s_awvalid_i,
	output logic                   s_awready_o,
	input  logic [`NIC_ADDR_W-1:0] s_awaddr_i,
	input  logic                   s_wvalid_i,
	output logic                   s_wready_o,
	input  logic [`NIC_DATA_W-1:0] s_wdata_i,
	input  logic [`NIC_STRB_W-1:0] s_wstrb_i,
	output logic                   s_bvalid_o,
	input  logic                   s_bready_i,
	output nic_pkg::resp_e         s_bresp_o,
	input  logic                   s_arvalid_i,
	output logic                   s_arready_o,
	input  logic [`NIC_ADDR_W-1:0] s_araddr_i,
	output logic                   s_rvalid_o,
	input  logic                   s_rready_i,
	output logic [`NIC_DATA_W-1:0] s_rdata_o,
	output nic_pkg::resp_e         s_rresp_o
);

	logic core_rst_q;

	logic                   rom_ren;
	logic [`NIC_ROM_AW-1:0] rom_addr;
	logic [15:0]            rom_rdata;

	// Host side and controller side register buses
	reg_bus_if host_bus ();
	reg_bus_if csr_bus ();

	// Core stays in reset until the clock source reports lock
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst)
			core_rst_q <= 1'b1;
		else if (pll_locked_i)
			core_rst_q <= 1'b0;
	end

	axi_lite_target u_axi_target (
		.core_clk    (core_clk),
		.core_rst    (core_rst_q),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_awaddr_i  (s_awaddr_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_bresp_o   (s_bresp_o),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_araddr_i  (s_araddr_i),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.bus_o       (host_bus)
	);

	target_crossbar u_xbar (
		.core_clk (core_clk),
		.core_rst (core_rst_q),
		.up_i     (host_bus),
		.down_o   (csr_bus)
	);

	nic_csr u_csr (
		.core_clk    (core_clk),
		.core_rst    (core_rst_q),
		.bus_i       (csr_bus),
		.link_up_i   (link_up_i),
		.intr_o      (intr_o),
		.rom_ren_o   (rom_ren),
		.rom_addr_o  (rom_addr),
		.rom_rdata_i (rom_rdata)
	);

	// EEPROM contents, read word by word through EERD
	config_rom u_rom (
		.core_clk    (core_clk),
		.rom_ren_i   (rom_ren),
		.rom_addr_i  (rom_addr),
		.rom_rdata_o (rom_rdata)
	);

endmodule

// File: logic/nic_csr.sv
`include "nic_defines.svh"

module nic_csr (
	input  logic                  core_clk,
	input  logic                  core_rst,
	reg_bus_if.target             bus_i,
	input  logic                  link_up_i,
	output logic                  intr_o,
	output logic                  rom_ren_o,
	output logic [`NIC_ROM_AW-1:0] rom_addr_o,
	input  logic [15:0]           rom_rdata_i
);

	logic [`NIC_BAR_BITS-1:0] off;
	logic                     wr_en;
	logic                     rd_en;
	logic [`NIC_DATA_W-1:0]   wmask;
	logic [`NIC_DATA_W-1:0]   wdata_m;
	logic [`NIC_DATA_W-1:0]   rd_data;
	logic [`NIC_DATA_W-1:0]   status_w;
	logic [`NIC_DATA_W-1:0]   icr_set;

	logic [`NIC_DATA_W-1:0]   ctrl_q;
	logic [`NIC_DATA_W-1:0]   icr_q;
	logic [`NIC_DATA_W-1:0]   ims_q;

	// Link input synchronizer and edge detect
	logic link_meta_q;
	logic link_q;
	logic link_prev_q;

	// EERD engine
	nic_pkg::eerd_u eerd_q;
	nic_pkg::eerd_u eerd_wr;
	logic           rom_ren_q;
	logic           rom_wait_q;
	logic           eerd_start;

	logic                   rsp_valid_q;
	logic [`NIC_DATA_W-1:0] rsp_rdata_q;

	always_comb begin
		off   = bus_i.req_addr[`NIC_BAR_BITS-1:0];
		wr_en = bus_i.req_valid && bus_i.req_write;
		rd_en = bus_i.req_valid && !bus_i.req_write;

		// Byte lanes to bit mask
		for (int i = 0; i < `NIC_STRB_W; i++)
			wmask[8*i +: 8] = {8{bus_i.req_strb[i]}};
		wdata_m = bus_i.req_wdata & wmask;
		eerd_wr = wdata_m;

		eerd_start = wr_en && (off == nic_pkg::EERD) && eerd_wr.cmd.start;

		status_w     = '0;
		status_w[19] = 1'b1;
		status_w[1]  = link_q;

		icr_set                     = '0;
		icr_set[nic_pkg::LSC]       = (link_q != link_prev_q);
		icr_set[nic_pkg::EERD_DONE] = rom_wait_q;

		case (off)
			nic_pkg::CTRL:   rd_data = ctrl_q;
			nic_pkg::STATUS: rd_data = status_w;
			nic_pkg::EERD:   rd_data = eerd_q;
			nic_pkg::ICR:    rd_data = icr_q;
			nic_pkg::IMS:    rd_data = ims_q;
			default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			ctrl_q      <= '0;
			icr_q       <= '0;
			ims_q       <= '0;
			link_meta_q <= 1'b0;
			link_q      <= 1'b0;
			link_prev_q <= 1'b0;
			eerd_q      <= '0;
			rom_ren_q   <= 1'b0;
			rom_wait_q  <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			link_meta_q <= link_up_i;
			link_q      <= link_meta_q;
			link_prev_q <= link_q;

			// One response per accepted request
			rsp_valid_q <= bus_i.req_valid;

			if (wr_en && off == nic_pkg::CTRL)
				ctrl_q <= (ctrl_q & ~wmask) | wdata_m;

			// Mask set and clear by writing ones
			if (wr_en && off == nic_pkg::IMS)
				ims_q <= ims_q | wdata_m;
			else if (wr_en && off == nic_pkg::IMC)
				ims_q <= ims_q & ~wdata_m;

			// Read clears causes, new events still land
			if (rd_en && off == nic_pkg::ICR)
				icr_q <= icr_set;
			else
				icr_q <= icr_q | icr_set;

			// ROM read issue, then data one cycle later
			rom_ren_q  <= eerd_start;
			rom_wait_q <= rom_ren_q;
			if (eerd_start) begin
				eerd_q.res.done <= 1'b0;
				eerd_q.res.addr <= eerd_wr.cmd.addr;
			end else if (rom_wait_q) begin
				eerd_q.res.done <= 1'b1;
				eerd_q.res.data <= rom_rdata_i;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (bus_i.req_valid)
			rsp_rdata_q <= rd_data;
	end

	assign bus_i.req_ready = 1'b1;
	assign bus_i.rsp_valid = rsp_valid_q;
	assign bus_i.rsp_rdata = rsp_rdata_q;
	assign bus_i.rsp_resp  = nic_pkg::OKAY;

	assign intr_o     = |(icr_q & ims_q);
	assign rom_ren_o  = rom_ren_q;
	assign rom_addr_o = eerd_q.res.addr;

	// A second ROM read never overlaps the one in flight
	rom_one_a: assert property (@(posedge core_clk) disable iff (core_rst)
		rom_ren_o |=> !rom_ren_o ##1 !rom_ren_o);

endmodule

// File: logic/nic_defines.svh
`ifndef NIC_DEFINES_SVH
`define NIC_DEFINES_SVH

// Host bus word geometry
`define NIC_ADDR_W 32
`define NIC_DATA_W 32
`define NIC_STRB_W 4

// Controller window at address zero, 128 KiB
`define NIC_BAR_BITS 17

// EEPROM word address width and populated words
`define NIC_ROM_AW 8
`define NIC_ROM_WORDS 64

// Station address, first octet in the top byte
`define NIC_MAC_ADDR 48'h02_1B_44_5C_7E_90

// Words 0..63 must add up to this, modulo 2^16
`define NIC_CHECKSUM 16'hBABA

`endif

// File: logic/nic_pkg.sv
`include "nic_defines.svh"

package nic_pkg;

	// AXI style response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// Register offsets inside the controller window
	typedef enum logic [`NIC_BAR_BITS-1:0] {
		CTRL   = 'h0000,
		STATUS = 'h0008,
		EERD   = 'h0014,
		ICR    = 'h00C0,
		IMS    = 'h00D0,
		IMC    = 'h00D8
	} csr_off_e;

	// Interrupt cause bit positions
	typedef enum logic [4:0] {
		LSC       = 5'd2,
		EERD_DONE = 5'd4
	} irq_bit_e;

	// EERD as written by the host
	typedef struct packed {
		logic [15:0] unused_hi;
		logic [7:0]  addr;
		logic [6:0]  unused_lo;
		logic        start;
	} eerd_cmd_t;

	// EERD as read back by the host
	typedef struct packed {
		logic [15:0] data;
		logic [7:0]  addr;
		logic [2:0]  pad_hi;
		logic        done;
		logic [3:0]  pad_lo;
	} eerd_res_t;

	typedef union packed {
		eerd_cmd_t cmd;
		eerd_res_t res;
	} eerd_u;

endpackage

// File: logic/reg_bus_if.sv
`include "nic_defines.svh"

// Single outstanding request/response register bus
interface reg_bus_if;

	// Request side
	logic                   req_valid;
	logic                   req_ready;
	logic                   req_write;
	logic [`NIC_ADDR_W-1:0] req_addr;
	logic [`NIC_DATA_W-1:0] req_wdata;
	logic [`NIC_STRB_W-1:0] req_strb;

	// Response side, one pulse per accepted request
	logic                   rsp_valid;
	logic [`NIC_DATA_W-1:0] rsp_rdata;
	nic_pkg::resp_e         rsp_resp;

	modport initiator (
		output req_valid, req_write, req_addr, req_wdata, req_strb,
		input  req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

	modport target (
		input  req_valid, req_write, req_addr, req_wdata, req_strb,
		output req_ready, rsp_valid, rsp_rdata, rsp_resp
	);

endinterface

// File: logic/target_crossbar.sv
`include "nic_defines.svh"

module target_crossbar (
	input  logic         core_clk,
	input  logic         core_rst,
	reg_bus_if.target    up_i,
	reg_bus_if.initiator down_o
);

	localparam int HI_BITS = `NIC_ADDR_W - `NIC_BAR_BITS;

	logic in_window;
	logic dec_pend_q;

	// Controller window starts at zero, so anything above it misses
	assign in_window = (up_i.req_addr[`NIC_ADDR_W-1:`NIC_BAR_BITS] == '0);

	// In-window requests go down with the window offset
	assign down_o.req_valid = up_i.req_valid && in_window;
	assign down_o.req_write = up_i.req_write;
	assign down_o.req_addr  = {{HI_BITS{1'b0}}, up_i.req_addr[`NIC_BAR_BITS-1:0]};
	assign down_o.req_wdata = up_i.req_wdata;
	assign down_o.req_strb  = up_i.req_strb;

	// Misses are taken at once
	assign up_i.req_ready = in_window ? down_o.req_ready : 1'b1;

	// Former CAN and UART windows land here too
	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst)
			dec_pend_q <= 1'b0;
		else
			dec_pend_q <= up_i.req_valid && !in_window;
	end

	// Merge both response sources
	assign up_i.rsp_valid = down_o.rsp_valid || dec_pend_q;
	assign up_i.rsp_rdata = dec_pend_q ? '0 : down_o.rsp_rdata;
	assign up_i.rsp_resp  = dec_pend_q ? nic_pkg::DECERR : down_o.rsp_resp;

	// Only one request is ever in flight
	one_src_a: assert property (@(posedge core_clk) disable iff (core_rst)
		!(dec_pend_q && down_o.rsp_valid));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_device_top \
	-o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

// File: tb.f
+incdir+logic
logic/nic_pkg.sv
logic/reg_bus_if.sv
logic/axi_lite_target.sv
logic/target_crossbar.sv
logic/nic_csr.sv
logic/config_rom.sv
logic/device_top.sv
tb/tb_device_top.sv

// File: tb/access_vectors.txt
// op addr data strb exp_data exp_resp backpressure, all hex
// op 0 write, 1 read, 2 EERD poll (data = word), 3 link toggle, 4 intr check, FF end
01 00000008 00000000 0 00080000 0 0
00 00000000 A5A5A5A5 F 00000000 0 0
01 00000000 00000000 0 A5A5A5A5 0 0
00 00000000 12345678 5 00000000 0 2
01 00000000 00000000 0 A534A578 0 3
00 00000000 FFFF0000 C 00000000 0 0
01 00000000 00000000 0 FFFFA578 0 0
00 00020000 DEADBEEF F 00000000 3 0
01 00020000 00000000 0 00000000 3 0
01 00040000 00000000 0 00000000 3 2
00 00040000 11111111 F 00000000 3 4
01 00060000 00000000 0 00000000 3 0
00 00060000 22222222 F 00000000 3 0
01 80000000 00000000 0 00000000 3 1
03 00000000 00000000 0 00000000 0 0
01 00000008 00000000 0 00080002 0 0
01 000000C0 00000000 0 00000004 0 0
00 000000D0 00000004 F 00000000 0 0
01 000000D0 00000000 0 00000004 0 0
03 00000000 00000000 0 00000001 0 0
01 000000C0 00000000 0 00000004 0 2
04 00000000 00000000 0 00000000 0 0
00 000000D8 00000004 F 00000000 0 0
03 00000000 00000000 0 00000000 0 0
01 000000C0 00000000 0 00000004 0 0
02 00000000 00000000 0 1B020010 0 0
02 00000000 00000001 0 5C440110 0 0
02 00000000 00000002 0 907E0210 0 0
02 00000000 00000040 0 FFFF4010 0 0
FF 00000000 00000000 0 00000000 0 0

// File: tb/tb_device_top.sv
`include "nic_defines.svh"

module tb_device_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF  = 50;
	localparam int DRIVE_DLY = 10;
	localparam int VEC_COLS  = 7;
	localparam int VEC_MAX   = 64;
	localparam int ROM_SWEEP = 64;

	// DUT inputs
	logic                   core_clk;
	logic                   ext_rst;
	logic                   pll_locked_i;
	logic                   link_up_i;
	logic                   s_awvalid_i;
	logic [`NIC_ADDR_W-1:0] s_awaddr_i;
	logic                   s_wvalid_i;
	logic [`NIC_DATA_W-1:0] s_wdata_i;
	logic [`NIC_STRB_W-1:0] s_wstrb_i;
	logic                   s_bready_i;
	logic                   s_arvalid_i;
	logic [`NIC_ADDR_W-1:0] s_araddr_i;
	logic                   s_rready_i;

	// DUT outputs
	logic                   intr_o;
	logic                   s_awready_o;
	logic                   s_wready_o;
	logic                   s_bvalid_o;
	nic_pkg::resp_e         s_bresp_o;
	logic                   s_arready_o;
	logic                   s_rvalid_o;
	logic [`NIC_DATA_W-1:0] s_rdata_o;
	nic_pkg::resp_e         s_rresp_o;

	// Vector table, seven words per access
	logic [31:0] vec_mem [0:VEC_COLS*VEC_MAX-1];
	int          vec_count = 0;
	int          err_count = 0;
	int          check_count = 0;
	logic        vectors_loaded = 1'b0;

	device_top i_device_top (
		.core_clk     (core_clk),
		.ext_rst      (ext_rst),
		.pll_locked_i (pll_locked_i),
		.link_up_i    (link_up_i),
		.intr_o       (intr_o),
		.s_awvalid_i  (s_awvalid_i),
		.s_awready_o  (s_awready_o),
		.s_awaddr_i   (s_awaddr_i),
		.s_wvalid_i   (s_wvalid_i),
		.s_wready_o   (s_wready_o),
		.s_wdata_i    (s_wdata_i),
		.s_wstrb_i    (s_wstrb_i),
		.s_bvalid_o   (s_bvalid_o),
		.s_bready_i   (s_bready_i),
		.s_bresp_o    (s_bresp_o),
		.s_arvalid_i  (s_arvalid_i),
		.s_arready_o  (s_arready_o),
		.s_araddr_i   (s_araddr_i),
		.s_rvalid_o   (s_rvalid_o),
		.s_rready_i   (s_rready_i),
		.s_rdata_o    (s_rdata_o),
		.s_rresp_o    (s_rresp_o)
	);

	initial begin
		core_clk = 1'b0;
		forever #CLK_HALF core_clk = ~core_clk;
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		check_count++;
		if (act_v !== exp_v) begin
			err_count++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge core_clk);
		#DRIVE_DLY;
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int bp, output nic_pkg::resp_e resp);
		int   aw_dly;
		int   w_dly;
		int   cyc;
		logic aw_pend;
		logic w_pend;
		logic aw_fire;
		logic w_fire;
		// Random skew between address and data
		aw_dly  = $urandom_range(3, 0);
		w_dly   = $urandom_range(3, 0);
		aw_pend = 1'b1;
		w_pend  = 1'b1;
		cyc     = 0;
		s_awaddr_i = addr;
		s_wdata_i  = data;
		s_wstrb_i  = strb;
		while (aw_pend || w_pend) begin
			s_awvalid_i = aw_pend && (cyc >= aw_dly);
			s_wvalid_i  = w_pend && (cyc >= w_dly);
			// Ready is registered, so this is what the next edge sees
			aw_fire = s_awvalid_i && s_awready_o;
			w_fire  = s_wvalid_i && s_wready_o;
			next_cycle();
			if (aw_fire)
				aw_pend = 1'b0;
			if (w_fire)
				w_pend = 1'b0;
			cyc++;
		end
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		while (!s_bvalid_o)
			next_cycle();
		resp = s_bresp_o;
		// Stall the B channel and watch it hold
		repeat (bp) begin
			next_cycle();
			check_val("s_bvalid_o", 32'd1, 32'(s_bvalid_o));
			check_val("s_bresp_o", 32'(resp), 32'(s_bresp_o));
		end
		s_bready_i = 1'b1;
		next_cycle();
		s_bready_i = 1'b0;
		check_val("s_bvalid_o", 32'd0, 32'(s_bvalid_o));
	endtask

	task automatic axi_read(input logic [31:0] addr, input int bp,
		output logic [31:0] data, output nic_pkg::resp_e resp);
		logic ar_fire;
		s_araddr_i = addr;
		s_arvalid_i = 1'b1;
		ar_fire = 1'b0;
		while (!ar_fire) begin
			ar_fire = s_arready_o;
			next_cycle();
		end
		s_arvalid_i = 1'b0;
		while (!s_rvalid_o)
			next_cycle();
		data = s_rdata_o;
		resp = s_rresp_o;
		repeat (bp) begin
			next_cycle();
			check_val("s_rvalid_o", 32'd1, 32'(s_rvalid_o));
			check_val("s_rdata_o", data, s_rdata_o);
			check_val("s_rresp_o", 32'(resp), 32'(s_rresp_o));
		end
		s_rready_i = 1'b1;
		next_cycle();
		s_rready_i = 1'b0;
		check_val("s_rvalid_o", 32'd0, 32'(s_rvalid_o));
	endtask

	// Start an EEPROM word read and poll EERD for done
	task automatic eerd_fetch(input logic [7:0] word_addr, output logic [31:0] result);
		nic_pkg::resp_e resp;
		int             polls;
		axi_write(32'h0000_0014, {16'h0000, word_addr, 8'h01}, 4'hF, 0, resp);
		check_val("s_bresp_o", 32'd0, 32'(resp));
		polls = 0;
		result = '0;
		while (!result[4] && polls < 8) begin
			axi_read(32'h0000_0014, 0, result, resp);
			check_val("s_rresp_o", 32'd0, 32'(resp));
			polls++;
		end
		if (!result[4]) begin
			err_count++;
			$display("EERD done bit never came up for word %0d", word_addr);
		end
	endtask

	initial begin
		logic [31:0]    op;
		logic [31:0]    addr;
		logic [31:0]    data;
		logic [31:0]    strb;
		logic [31:0]    exp_d;
		logic [31:0]    exp_r;
		logic [31:0]    bp;
		logic [31:0]    rdata;
		logic [15:0]    sum;
		logic [7:0]     word_addr;
		nic_pkg::resp_e resp;
		void'($urandom(32'h74b4));
		ext_rst      = 1'b1;
		pll_locked_i = 1'b0;
		link_up_i    = 1'b0;
		s_awvalid_i  = 1'b0;
		s_awaddr_i   = '0;
		s_wvalid_i   = 1'b0;
		s_wdata_i    = '0;
		s_wstrb_i    = '0;
		s_bready_i   = 1'b0;
		s_arvalid_i  = 1'b0;
		s_araddr_i   = '0;
		s_rready_i   = 1'b0;
		$readmemh("tb/access_vectors.txt", vec_mem);
		while (vec_count < VEC_MAX && vec_mem[vec_count*VEC_COLS] !== 32'hFF)
			vec_count++;
		vectors_loaded = 1'b1;

		// Sixteen cycles of reset, lock two cycles after release
		repeat (16) next_cycle();
		check_val("s_awready_o", 32'd0, 32'(s_awready_o));
		check_val("s_wready_o", 32'd0, 32'(s_wready_o));
		check_val("s_arready_o", 32'd0, 32'(s_arready_o));
		ext_rst = 1'b0;
		repeat (2) next_cycle();
		pll_locked_i = 1'b1;
		repeat (2) next_cycle();
		check_val("s_bvalid_o", 32'd0, 32'(s_bvalid_o));
		check_val("s_rvalid_o", 32'd0, 32'(s_rvalid_o));
		check_val("intr_o", 32'd0, 32'(intr_o));

		for (int v = 0; v < vec_count; v++) begin
			op    = vec_mem[v*VEC_COLS];
			addr  = vec_mem[v*VEC_COLS+1];
			data  = vec_mem[v*VEC_COLS+2];
			strb  = vec_mem[v*VEC_COLS+3];
			exp_d = vec_mem[v*VEC_COLS+4];
			exp_r = vec_mem[v*VEC_COLS+5];
			bp    = vec_mem[v*VEC_COLS+6];
			case (op)
				32'h0: begin
					axi_write(addr, data, strb[3:0], int'(bp), resp);
					check_val("s_bresp_o", exp_r, 32'(resp));
				end
				32'h1: begin
					axi_read(addr, int'(bp), rdata, resp);
					check_val("s_rdata_o", exp_d, rdata);
					check_val("s_rresp_o", exp_r, 32'(resp));
				end
				32'h2: begin
					eerd_fetch(data[7:0], rdata);
					check_val("eerd_result", exp_d, rdata);
				end
				32'h3: begin
					// Three flops of sync and cause capture, with margin
					link_up_i = ~link_up_i;
					repeat (8) next_cycle();
					check_val("intr_o", {31'd0, exp_d[0]}, 32'(intr_o));
				end
				32'h4: check_val("intr_o", {31'd0, exp_d[0]}, 32'(intr_o));
				default: begin
					err_count++;
					$display("Unknown operation %h in vector %0d", op, v);
				end
			endcase
		end

		// Full ROM sweep, low words are ~addr and all 64 sum to the checksum
		sum = '0;
		for (int w = 0; w < ROM_SWEEP; w++) begin
			word_addr = w[7:0];
			eerd_fetch(word_addr, rdata);
			check_val("eerd_addr_done", {16'h0000, word_addr, 8'h10}, {16'h0000, rdata[15:0]});
			if (w >= 3 && w < 63)
				check_val("eerd_data", {24'h0, ~word_addr}, {16'h0000, rdata[31:16]});
			sum = sum + rdata[31:16];
		end
		check_val("rom_checksum", {16'h0000, `NIC_CHECKSUM}, {16'h0000, sum});

		$display("Checks run: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Budget of 200 cycles per access plus the ROM sweep
	initial begin
		wait (vectors_loaded);
		repeat ((vec_count + ROM_SWEEP) * 200 + 64) @(posedge core_clk);
		$display("Timeout: the accesses did not finish in the cycle budget");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
